//--- video_pkg.sv
// shared constants and types for the mono 640x400 72 Hz raster and the 256x128 OSD window
`default_nettype none

package video_pkg;

	// horizontal timing in clocks; active pixels begin after the read prefetch
	localparam logic [9:0] h_pre  = 10'd16;
	localparam logic [9:0] h_act  = 10'd640;
	localparam logic [9:0] h_fp   = 10'd24;
	localparam logic [9:0] h_sync = 10'd40;
	localparam logic [9:0] h_bp   = 10'd128;
	localparam logic [9:0] h_tot  = h_act + h_fp + h_sync + h_bp;

	// vertical timing in lines
	localparam logic [9:0] v_act  = 10'd400;
	localparam logic [9:0] v_fp   = 10'd55;
	localparam logic [9:0] v_sync = 10'd3;
	localparam logic [9:0] v_bp   = 10'd73;
	localparam logic [9:0] v_tot  = v_act + v_fp + v_sync + v_bp;

	// 640 pixels / 16 bits per word
	localparam logic [5:0] words_per_line = 6'd40;

	// OSD window, centred; rows are doubled so 128 lines hold 64 pixel rows
	localparam logic [9:0] osd_width  = 10'd256;
	localparam logic [9:0] osd_height = 10'd128;
	localparam logic [9:0] osd_pos_x  = 10'd192;
	localparam logic [9:0] osd_pos_y  = 10'd136;
	localparam logic [9:0] osd_border = 10'd2;
	localparam int osd_buf_depth = 2048;

	// video memory word address
	typedef logic [22:0] vaddr_t;

	typedef enum logic [1:0] {
		osd_cmd_none,
		osd_cmd_write,
		osd_cmd_enable
	} osd_cmd_e;

	// upper five bits select the command, lower three carry its argument
	function automatic osd_cmd_e osd_cmd_decode(input logic [7:0] cmd_byte);
		case (cmd_byte[7:3])
			5'b00100: return osd_cmd_write;
			5'b01000: return osd_cmd_enable;
			default:  return osd_cmd_none;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- raster_if.sv
// raster position and strobes, all levels or one-clock pulses with no handshake
`timescale 1ns/1ps
`default_nettype none

interface raster_if;
	// position counters
	logic [9:0] hcnt;
	logic [9:0] vcnt;
	// decoded strobes
	logic de;
	logic fetch;
	logic hsync;
	logic vsync;
	logic frame_end;

	// timing generator side
	modport src (output hcnt, vcnt, de, fetch, hsync, vsync, frame_end);
	// fetch, OSD and mixer side
	modport snk (input hcnt, vcnt, de, fetch, hsync, vsync, frame_end);
endinterface

`default_nettype wire

//--- raster_timing.sv
// 832x531 mono raster; counters start at zero in the first clock after ss falls
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
	input  logic  clk,
	input  logic  ss,
	raster_if.src rif
);
	import video_pkg::*;

	logic [9:0] hcnt;
	logic [9:0] vcnt;

	// horizontal counter wraps at h_tot, vertical steps on the wrap
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == h_tot - 10'd1) begin
			hcnt <= '0;
			if (vcnt == v_tot - 10'd1)
				vcnt <= '0;
			else
				vcnt <= vcnt + 10'd1;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	assign rif.hcnt = hcnt;
	assign rif.vcnt = vcnt;

	// visible pixels lag the reads by the prefetch
	assign rif.de = (hcnt >= h_pre) && (hcnt < h_pre + h_act) && (vcnt < v_act);

	// one read every 16 clocks, starting at hcnt 0
	assign rif.fetch = (hcnt < h_act) && (vcnt < v_act) && (hcnt[3:0] == 4'd0);

	// syncs measured from the end of the delayed active area
	assign rif.hsync = (hcnt >= h_pre + h_act + h_fp) &&
		(hcnt < h_pre + h_act + h_fp + h_sync);
	assign rif.vsync = (vcnt >= v_act + v_fp) && (vcnt < v_act + v_fp + v_sync);

	// well behind the last read, safe spot to restart the address counter
	assign rif.frame_end = (hcnt == h_pre + h_act + h_fp) && (vcnt == v_act + v_fp);

	// counters stay inside the frame
	a_hcnt_range: assert property (@(posedge clk) disable iff (ss)
		(hcnt < h_tot) && (vcnt < v_tot));

endmodule

`default_nettype wire

//--- mono_fetch.sv
// data must be valid exactly one clock after each read; base_addr is taken at reset and frame end
`timescale 1ns/1ps
`default_nettype none

module mono_fetch (
	input  logic            clk,
	input  logic            ss,
	raster_if.snk           rif,
	input  video_pkg::vaddr_t base_addr,
	input  logic            invert,
	input  logic [15:0]     data,
	output video_pkg::vaddr_t vaddr,
	output logic            pixel
);
	import video_pkg::*;

	logic        fetch_d;
	logic [15:0] data_q;
	logic [15:0] shreg;

	// word address counter
	always_ff @(posedge clk or posedge ss) begin
		if (ss)
			vaddr <= base_addr;
		else if (rif.frame_end)
			vaddr <= base_addr;
		else if (rif.fetch)
			vaddr <= vaddr + 23'd1;
	end

	// marks the clock in which memory returns the word
	always_ff @(posedge clk or posedge ss) begin
		if (ss)
			fetch_d <= 1'b0;
		else
			fetch_d <= rif.fetch;
	end

	// capture register and shifter
	always_ff @(posedge clk) begin
		if (fetch_d)
			data_q <= data;
		// reload just before each 16-pixel group
		if (rif.hcnt[3:0] == 4'd15)
			shreg <= data_q;
		else
			shreg <= {shreg[14:0], 1'b0};
	end

	// msb first, optionally inverted
	assign pixel = shreg[15] ^ invert;

	// reads only inside the active lines, each one shown a prefetch later
	a_fetch_active: assert property (@(posedge clk) disable iff (ss)
		rif.fetch |-> (rif.vcnt < v_act) && (rif.hcnt < h_act) ##16 rif.de);

endmodule

`default_nettype wire

//--- osd_spi_rx.sv
// serial OSD receiver; sck is sampled in the clk domain so it must stay below clk/4
`timescale 1ns/1ps
`default_nettype none

module osd_spi_rx (
	input  logic        clk,
	input  logic        ss,
	input  logic        sck,
	input  logic        spi_cs,
	input  logic        sdi,
	output logic        wr_en,
	output logic [10:0] wr_addr,
	output logic [7:0]  wr_data,
	output logic        osd_enable
);
	import video_pkg::*;

	// two-stage synchronisers, index 1 is the stable copy
	logic [1:0] sck_s;
	logic [1:0] cs_s;
	logic [1:0] sdi_s;
	logic       sck_d;
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic       have_cmd;
	logic [7:0] sbuf;
	logic [7:0] rx_byte;
	osd_cmd_e   cmd;
	logic [10:0] bcnt;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			sck_s <= '0;
			cs_s  <= 2'b11;
			sdi_s <= '0;
			sck_d <= 1'b0;
		end else begin
			sck_s <= {sck_s[0], sck};
			cs_s  <= {cs_s[0], spi_cs};
			sdi_s <= {sdi_s[0], sdi};
			sck_d <= sck_s[1];
		end
	end

	assign sck_rise = sck_s[1] && !sck_d;
	// byte including the bit arriving now
	assign rx_byte = {sbuf[6:0], sdi_s[1]};

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			bit_cnt    <= '0;
			have_cmd   <= 1'b0;
			cmd        <= osd_cmd_none;
			bcnt       <= '0;
			wr_en      <= 1'b0;
			osd_enable <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (cs_s[1]) begin
				// deselected, next byte is a command again
				bit_cnt  <= '0;
				have_cmd <= 1'b0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7 && !have_cmd) begin
					have_cmd <= 1'b1;
					cmd      <= osd_cmd_decode(rx_byte);
					// low three bits pick the 256-byte line
					bcnt     <= {rx_byte[2:0], 8'h00};
					if (osd_cmd_decode(rx_byte) == osd_cmd_enable)
						osd_enable <= rx_byte[0];
				end else if (bit_cnt == 3'd7 && cmd == osd_cmd_write) begin
					wr_en <= 1'b1;
					bcnt  <= bcnt + 11'd1;
				end
			end
		end
	end

	// shift register and write payload
	always_ff @(posedge clk) begin
		if (sck_rise)
			sbuf <= rx_byte;
		if (sck_rise && bit_cnt == 3'd7) begin
			wr_addr <= bcnt;
			wr_data <= rx_byte;
		end
	end

	// link stays selected through the clock of each write
	a_wr_selected: assert property (@(posedge clk) disable iff (ss)
		wr_en |-> !cs_s[1]);

endmodule

`default_nettype wire

//--- osd_overlay.sv
// OSD buffer and window; the window is placed on raw hcnt, not on the prefetch-shifted pixels
`timescale 1ns/1ps
`default_nettype none

module osd_overlay (
	input  logic  clk,
	input  logic  ss,
	input  logic  sck,
	input  logic  spi_cs,
	input  logic  sdi,
	raster_if.snk rif,
	output logic  osd_oe,
	output logic  osd_pixel
);
	import video_pkg::*;

	logic        wr_en;
	logic [10:0] wr_addr;
	logic [7:0]  wr_data;
	logic        osd_enable;
	logic [7:0]  osd_buf [osd_buf_depth];
	logic [7:0]  osd_byte;
	logic [9:0]  col_next;
	logic [9:0]  row;
	logic        content;

	osd_spi_rx u_rx (
		.clk       (clk),
		.ss        (ss),
		.sck       (sck),
		.spi_cs    (spi_cs),
		.sdi       (sdi),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.osd_enable(osd_enable)
	);

	// one column ahead, the read below costs a clock
	assign col_next = rif.hcnt - osd_pos_x + 10'd1;
	assign row      = rif.vcnt - osd_pos_y;

	always_ff @(posedge clk) begin
		if (wr_en)
			osd_buf[wr_addr] <= wr_data;
		// 16 raster lines per 256-byte line
		osd_byte <= osd_buf[{row[6:4], col_next[7:0]}];
	end

	// window including the border ring
	assign osd_oe = osd_enable &&
		(rif.hcnt >= osd_pos_x - osd_border) &&
		(rif.hcnt < osd_pos_x + osd_width + osd_border) &&
		(rif.vcnt >= osd_pos_y - osd_border) &&
		(rif.vcnt < osd_pos_y + osd_height + osd_border);

	assign content = (rif.hcnt >= osd_pos_x) && (rif.hcnt < osd_pos_x + osd_width) &&
		(rif.vcnt >= osd_pos_y) && (rif.vcnt < osd_pos_y + osd_height);

	// border reads as dark, rows doubled
	assign osd_pixel = content ? osd_byte[row[3:1]] : 1'b0;

endmodule

`default_nettype wire

//--- video_mixer.sv
// every output is registered, one clock behind the raster position; syncs active low
`timescale 1ns/1ps
`default_nettype none

module video_mixer (
	input  logic       clk,
	input  logic       ss,
	raster_if.snk      rif,
	input  logic       pixel,
	input  logic       osd_oe,
	input  logic       osd_pixel,
	output logic [5:0] video_r,
	output logic [5:0] video_g,
	output logic [5:0] video_b,
	output logic       hs,
	output logic       vs
);
	logic [2:0] s;
	logic [2:0] p;

	// blank outside the active area
	assign s = {3{rif.de & pixel}};
	assign p = {3{osd_pixel}};

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			video_r <= '0;
			video_g <= '0;
			video_b <= '0;
			hs      <= 1'b1;
			vs      <= 1'b1;
		end else begin
			// OSD on top, screen kept in the low bits; green tint
			video_r <= osd_oe ? {p, s} : {s, s};
			video_g <= osd_oe ? {p[2:1], 1'b1, s} : {s, s};
			video_b <= osd_oe ? {p, s} : {s, s};
			hs      <= ~rif.hsync;
			vs      <= ~rif.vsync;
		end
	end

endmodule

`default_nettype wire

//--- mono_video.sv
// mono video top; read is combinational and data is expected one clock after it
`timescale 1ns/1ps
`default_nettype none

module mono_video (
	input  logic              clk,
	input  logic              ss,
	input  video_pkg::vaddr_t base_addr,
	input  logic              invert,
	input  logic [15:0]       data,
	input  logic              sck,
	input  logic              spi_cs,
	input  logic              sdi,
	output video_pkg::vaddr_t vaddr,
	output logic              read,
	output logic [5:0]        video_r,
	output logic [5:0]        video_g,
	output logic [5:0]        video_b,
	output logic              hs,
	output logic              vs
);
	logic pixel;
	logic osd_oe;
	logic osd_pixel;

	raster_if rif ();

	raster_timing u_timing (
		.clk(clk),
		.ss (ss),
		.rif(rif.src)
	);

	// memory strobe straight from the raster decode
	assign read = rif.fetch;

	mono_fetch u_fetch (
		.clk      (clk),
		.ss       (ss),
		.rif      (rif.snk),
		.base_addr(base_addr),
		.invert   (invert),
		.data     (data),
		.vaddr    (vaddr),
		.pixel    (pixel)
	);

	osd_overlay u_osd (
		.clk      (clk),
		.ss       (ss),
		.sck      (sck),
		.spi_cs   (spi_cs),
		.sdi      (sdi),
		.rif      (rif.snk),
		.osd_oe   (osd_oe),
		.osd_pixel(osd_pixel)
	);

	video_mixer u_mixer (
		.clk      (clk),
		.ss       (ss),
		.rif      (rif.snk),
		.pixel    (pixel),
		.osd_oe   (osd_oe),
		.osd_pixel(osd_pixel),
		.video_r  (video_r),
		.video_g  (video_g),
		.video_b  (video_b),
		.hs       (hs),
		.vs       (vs)
	);

endmodule

`default_nettype wire

//--- tb_mono_video.sv
// self-checking testbench; the OSD is loaded while disabled, and enable changes only on line 300
`timescale 1ns/1ps
`default_nettype none

module tb_mono_video;

	// two 441,792-clock frames, most of a third and the OSD load, with margin
	localparam int timeout_cycles = 2_000_000;

	logic        clk;
	logic        ss;
	logic [22:0] base_addr;
	logic        invert;
	logic [15:0] data;
	logic        sck;
	logic        spi_cs;
	logic        sdi;
	logic [22:0] vaddr;
	logic        read;
	logic [5:0]  video_r;
	logic [5:0]  video_g;
	logic [5:0]  video_b;
	logic        hs;
	logic        vs;

	// reference model state
	int          mh;
	int          mv;
	int          cycles;
	int          checks;
	int          errors;
	int          line_reads;
	int          frame_reads;
	int          last_hs_fall;
	int          last_vs_fall;
	logic        hs_q;
	logic        vs_q;
	logic        have_prev;
	logic        model_en;
	logic        exp_read;
	logic        sp;
	logic        p;
	logic        oe_m;
	logic [2:0]  s3;
	logic [22:0] exp_vaddr;
	logic [5:0]  exp_r;
	logic [5:0]  exp_g;
	logic [5:0]  exp_b;
	logic        exp_hs;
	logic        exp_vs;
	logic [31:0] salt;
	logic [15:0] line_words [40];
	logic [7:0]  osd_mem [2048];

	mono_video dut (
		.clk      (clk),
		.ss       (ss),
		.base_addr(base_addr),
		.invert   (invert),
		.data     (data),
		.sck      (sck),
		.spi_cs   (spi_cs),
		.sdi      (sdi),
		.vaddr    (vaddr),
		.read     (read),
		.video_r  (video_r),
		.video_g  (video_g),
		.video_b  (video_b),
		.hs       (hs),
		.vs       (vs)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory contents as a hash of the whole word address
	function automatic logic [15:0] word_at(input logic [22:0] addr);
		logic [31:0] x;
		x = {9'd0, addr} ^ salt;
		x = x * 32'h9e37_79b1;
		x = x ^ (x >> 15);
		return x[15:0];
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			if (errors <= 20)
				$display("[FAIL] %s at cycle %0d: expected %0h actual %0h",
					name, cycles, expected, actual);
		end
	endtask

	// memory model, word arrives one clock after the strobe, garbage otherwise
	always @(posedge clk) begin
		if (read)
			data <= word_at(vaddr);
		else
			data <= 16'($urandom);
	end

	// occasional invert flips, even in mid line
	always @(posedge clk) begin
		if (!ss && ($urandom % 700) == 0)
			invert <= ~invert;
	end

	// serial byte at clk/8, msb first, sdi changes with the falling sck
	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk);
			sck <= 1'b0;
			sdi <= b[i];
			repeat (4) @(posedge clk);
			sck <= 1'b1;
			repeat (3) @(posedge clk);
		end
	endtask

	task automatic select_link(input logic sel);
		repeat (4) @(posedge clk);
		spi_cs <= ~sel;
		repeat (4) @(posedge clk);
	endtask

	// one write command with a full 256-byte OSD line
	task automatic load_line(input int line);
		logic [7:0] b;
		select_link(1'b1);
		send_byte({5'b00100, 3'(line)});
		for (int i = 0; i < 256; i++) begin
			b = 8'($urandom);
			osd_mem[line * 256 + i] = b;
			send_byte(b);
		end
		select_link(1'b0);
	endtask

	task automatic set_osd(input logic en);
		select_link(1'b1);
		send_byte({7'b0100_000, en});
		select_link(1'b0);
		model_en = en;
	endtask

	task automatic wait_line(input int line);
		do
			@(posedge clk);
		while (mv != line);
	endtask

	// reference model, sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		if (ss) begin
			mh = 0;
			mv = 0;
			exp_vaddr = base_addr;
			have_prev = 1'b0;
			hs_q = 1'b1;
			vs_q = 1'b1;
		end else begin
			// registered outputs belong to the previous position
			if (have_prev) begin
				compare("video_r", exp_r, video_r);
				compare("video_g", exp_g, video_g);
				compare("video_b", exp_b, video_b);
				compare("hs", exp_hs, hs);
				compare("vs", exp_vs, vs);
			end
			// line and frame periods from the sync falling edges
			if (hs_q && !hs) begin
				if (last_hs_fall >= 0)
					compare("hs_period", 832, cycles - last_hs_fall);
				last_hs_fall = cycles;
			end
			if (vs_q && !vs) begin
				if (last_vs_fall >= 0)
					compare("vs_period", 832 * 531, cycles - last_vs_fall);
				last_vs_fall = cycles;
			end
			hs_q = hs;
			vs_q = vs;

			exp_read = (mh < 640) && (mv < 400) && (mh % 16 == 0);
			compare("read", exp_read, read);
			compare("vaddr", exp_vaddr, vaddr);
			if (mh == 0 && mv == 0)
				compare("vaddr_frame_start", base_addr, vaddr);
			if (exp_read)
				line_words[mh / 16] = word_at(exp_vaddr);
			// strobe totals counted on the DUT's read
			if (read) begin
				line_reads++;
				frame_reads++;
			end

			// mono pixel, word k shown 16 clocks after its read
			sp = 1'b0;
			if (mh >= 16 && mh < 656 && mv < 400)
				sp = line_words[(mh - 16) / 16][15 - ((mh - 16) % 16)] ^ invert;
			s3 = {3{sp}};
			oe_m = model_en && mh >= 190 && mh < 450 && mv >= 134 && mv < 266;
			// border ring stays dark, rows doubled
			p = 1'b0;
			if (mh >= 192 && mh < 448 && mv >= 136 && mv < 264)
				p = osd_mem[((mv - 136) / 16) * 256 + (mh - 192)][((mv - 136) / 2) % 8];
			exp_r = oe_m ? {{3{p}}, s3} : {s3, s3};
			exp_g = oe_m ? {p, p, 1'b1, s3} : {s3, s3};
			exp_b = exp_r;
			exp_hs = !(mh >= 680 && mh < 720);
			exp_vs = !(mv >= 455 && mv < 458);
			have_prev = 1'b1;

			// address counter for the next clock
			if (mh == 680 && mv == 455) begin
				compare("frame_reads", 16000, frame_reads);
				frame_reads = 0;
				exp_vaddr = base_addr;
			end else if (exp_read) begin
				exp_vaddr = exp_vaddr + 23'd1;
			end

			if (mh == 831) begin
				if (mv < 400)
					compare("line_reads", 40, line_reads);
				line_reads = 0;
				mh = 0;
				mv = (mv == 530) ? 0 : mv + 1;
			end else begin
				mh++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout: run still going after %0d cycles, %0d errors so far",
				cycles, errors);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		// first draw of the seeded generator doubles as the memory salt
		salt = $urandom(78);
		cycles = 0;
		checks = 0;
		errors = 0;
		line_reads = 0;
		frame_reads = 0;
		last_hs_fall = -1;
		last_vs_fall = -1;
		model_en = 1'b0;
		ss <= 1'b1;
		base_addr <= 23'($urandom);
		invert <= 1'b0;
		data <= '0;
		sck <= 1'b0;
		spi_cs <= 1'b1;
		sdi <= 1'b0;
		repeat (10) @(posedge clk);
		ss <= 1'b0;

		// fill the whole buffer while the overlay is hidden
		for (int l = 0; l < 8; l++)
			load_line(l);
		// line 300 lies below the window, so the switch is invisible
		wait_line(300);
		set_osd(1'b1);
		wait_line(420);
		base_addr <= 23'($urandom);
		wait_line(0);
		wait_line(300);
		set_osd(1'b0);
		wait_line(420);
		base_addr <= 23'($urandom);
		wait_line(0);
		wait_line(280);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
video_pkg.sv
raster_if.sv
raster_timing.sv
mono_fetch.sv
osd_spi_rx.sv
osd_overlay.sv
video_mixer.sv
mono_video.sv
tb_mono_video.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mono video testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mono_video -f sources.f \
	--Mdir obj_dir -o sim_mono_video; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_mono_video > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1
